//--- logic/cordic_pkg.sv
package cordic_pkg;

    localparam int CORDIC_NUM = 14;   // micro-rotations per unit
    localparam int PIPE_NUM   = 4;    // registers per unit
    localparam int SEG_NUM    = 3;

    // rotations handled by each pipeline segment
    localparam int SEG0_LEN = 4;
    localparam int SEG1_LEN = 5;
    localparam int SEG2_LEN = 5;

    // about 0.607 * 2^14
    localparam logic [14:0] GAIN_K = 15'd9949;

    typedef struct packed {
        logic [SEG2_LEN-1:0] seg2;
        logic [SEG1_LEN-1:0] seg1;
        logic [SEG0_LEN-1:0] seg0;
    } dir_seg_t;

    // one direction bit per micro-rotation, bit 0 is shift 0
    typedef union packed {
        logic [CORDIC_NUM-1:0] bits;
        dir_seg_t              seg;
    } dir_word_u;

    // per segment, take fresh where sel is set, else held
    function automatic dir_word_u seg_merge(input dir_word_u fresh,
                                            input dir_word_u held,
                                            input logic [SEG_NUM-1:0] sel);
        dir_word_u m;
        m.seg.seg0 = sel[0] ? fresh.seg.seg0 : held.seg.seg0;
        m.seg.seg1 = sel[1] ? fresh.seg.seg1 : held.seg.seg1;
        m.seg.seg2 = sel[2] ? fresh.seg.seg2 : held.seg.seg2;
        return m;
    endfunction

endpackage

//--- logic/pe_pkg.sv
package pe_pkg;

    // scheme select of the processing element
    typedef enum logic [1:0] {
        SCH_VEC_VEC      = 2'b00,  // both units vector
        SCH_ROT_ROT      = 2'b01,  // both rotate on stored angles
        SCH_SWAP_VEC_ROT = 2'b10,  // swapped, unit 1 follows unit 0
        SCH_SWAP_ROT_ROT = 2'b11   // swapped, both rotate
    } scheme_e;

    typedef enum logic {
        MODE_VECTOR = 1'b0,
        MODE_ROTATE = 1'b1
    } cordic_mode_e;

endpackage

//--- logic/cordic_pipe.sv
module cordic_pipe #(
    parameter int BITWIDTH = 18
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start_i,
    input  pe_pkg::cordic_mode_e       mode_i,
    input  logic signed [BITWIDTH-1:0] x_i,
    input  logic signed [BITWIDTH-1:0] y_i,
    input  cordic_pkg::dir_word_u      d_i,
    output logic signed [BITWIDTH-1:0] x_o,
    output logic signed [BITWIDTH-1:0] y_o,
    output cordic_pkg::dir_word_u      d_o
);
    import cordic_pkg::*;
    import pe_pkg::*;

    localparam int W  = BITWIDTH + 1;   // one guard bit for growth
    localparam int PW = 15 + BITWIDTH;  // gain product width

    logic signed [W-1:0] x_q [PIPE_NUM-1];
    logic signed [W-1:0] y_q [PIPE_NUM-1];
    logic signed [W-1:0] x_n [PIPE_NUM-1];
    logic signed [W-1:0] y_n [PIPE_NUM-1];
    logic signed [BITWIDTH-1:0] x_out_q;
    logic signed [BITWIDTH-1:0] y_out_q;
    logic signed [PW-1:0] x_prod;
    logic signed [PW-1:0] y_prod;
    logic [CORDIC_NUM-1:0] d_seg [SEG_NUM];
    cordic_mode_e mode_q [PIPE_NUM-2];  // modes for stages 1 and 2
    cordic_mode_e mode_n;

    // run micro-rotations lo .. lo+len-1 on one segment
    function automatic void cordic_seg(input  logic signed [W-1:0] x_in,
                                       input  logic signed [W-1:0] y_in,
                                       input  cordic_mode_e          mode,
                                       input  logic [CORDIC_NUM-1:0] d,
                                       input  int                    lo,
                                       input  int                    len,
                                       output logic signed [W-1:0] x_out,
                                       output logic signed [W-1:0] y_out,
                                       output logic [CORDIC_NUM-1:0] d_out);
        logic signed [W-1:0] x;
        logic signed [W-1:0] y;
        logic signed [W-1:0] xt;
        logic dir;
        x = x_in;
        y = y_in;
        d_out = '0;
        for (int k = lo; k < lo + len; k++) begin
            // vectoring drives y toward zero
            dir = (mode == MODE_VECTOR) ? (x[W-1] ^ y[W-1]) : d[k];
            if (mode == MODE_VECTOR) begin
                d_out[k] = dir;
            end
            xt = x;
            if (dir) begin
                x = x - (y >>> k);
                y = y + (xt >>> k);
            end else begin
                x = x + (y >>> k);
                y = y - (xt >>> k);
            end
        end
        x_out = x;
        y_out = y;
    endfunction

    always_comb begin
        cordic_seg({x_i[BITWIDTH-1], x_i}, {y_i[BITWIDTH-1], y_i}, mode_i, d_i.bits,
                   0, SEG0_LEN, x_n[0], y_n[0], d_seg[0]);
        cordic_seg(x_q[0], y_q[0], mode_q[0], d_i.bits,
                   SEG0_LEN, SEG1_LEN, x_n[1], y_n[1], d_seg[1]);
        cordic_seg(x_q[1], y_q[1], mode_q[1], d_i.bits,
                   SEG0_LEN + SEG1_LEN, SEG2_LEN, x_n[2], y_n[2], d_seg[2]);
    end

    assign d_o = d_seg[0] | d_seg[1] | d_seg[2];

    // idle slots travel as rotate so they never report directions
    assign mode_n = start_i ? mode_i : MODE_ROTATE;

    assign x_prod = x_q[PIPE_NUM-2] * $signed(GAIN_K);
    assign y_prod = y_q[PIPE_NUM-2] * $signed(GAIN_K);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < PIPE_NUM - 1; s++) begin
                x_q[s] <= '0;
                y_q[s] <= '0;
            end
            for (int s = 0; s < PIPE_NUM - 2; s++) begin
                mode_q[s] <= MODE_ROTATE;
            end
            x_out_q <= '0;
            y_out_q <= '0;
        end else begin
            for (int s = 0; s < PIPE_NUM - 1; s++) begin
                x_q[s] <= x_n[s];
                y_q[s] <= y_n[s];
            end
            mode_q[0] <= mode_n;
            for (int s = 1; s < PIPE_NUM - 2; s++) begin
                mode_q[s] <= mode_q[s-1];
            end
            // gain stage, drop the fraction of K
            x_out_q <= {x_prod[PW-1], x_prod[14+BITWIDTH-2:BITWIDTH-4]};
            y_out_q <= {y_prod[PW-1], y_prod[14+BITWIDTH-2:BITWIDTH-4]};
        end
    end

    assign x_o = x_out_q;
    assign y_o = y_out_q;

endmodule

//--- logic/pe_ctrl.sv
module pe_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [1:0]                     valid_i,
    input  pe_pkg::scheme_e                scheme_i,
    output pe_pkg::cordic_mode_e           mode0_o,
    output pe_pkg::cordic_mode_e           mode1_o,
    output logic                           swap_in_o,
    output logic                           swap_out_o,
    output logic [cordic_pkg::SEG_NUM-1:0] val0_o,
    output logic [cordic_pkg::SEG_NUM-1:0] val1_o,
    output logic [cordic_pkg::SEG_NUM-1:0] share_o
);
    import cordic_pkg::*;
    import pe_pkg::*;

    logic [PIPE_NUM-1:0] swap_q;   // swap flag per pipeline stage
    logic [SEG_NUM-2:0]  v0_q;
    logic [SEG_NUM-2:0]  v1_q;
    logic [SEG_NUM-1:0]  val1_own;
    logic                vec0;
    logic                vec1;

    always_comb begin
        mode0_o   = MODE_ROTATE;
        mode1_o   = MODE_ROTATE;
        swap_in_o = 1'b0;
        case (scheme_i)
            SCH_VEC_VEC: begin
                mode0_o = MODE_VECTOR;
                mode1_o = MODE_VECTOR;
            end
            SCH_SWAP_VEC_ROT: begin
                mode0_o   = MODE_VECTOR;
                swap_in_o = 1'b1;
            end
            SCH_SWAP_ROT_ROT: begin
                swap_in_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign vec0 = valid_i[0] & (mode0_o == MODE_VECTOR);
    assign vec1 = valid_i[1] & (mode1_o == MODE_VECTOR);

    // segment k of the item issued k cycles ago
    assign share_o  = {swap_q[SEG_NUM-2:0], swap_in_o};
    assign val0_o   = {v0_q, vec0};
    assign val1_own = {v1_q, vec1};
    assign val1_o   = (val1_own & ~share_o) | (val0_o & share_o);

    assign swap_out_o = swap_q[PIPE_NUM-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            swap_q <= '0;
            v0_q   <= '0;
            v1_q   <= '0;
        end else begin
            swap_q <= {swap_q[PIPE_NUM-2:0], swap_in_o};
            v0_q   <= {v0_q[SEG_NUM-3:0], vec0};
            v1_q   <= {v1_q[SEG_NUM-3:0], vec1};
        end
    end

endmodule

//--- logic/operand_xbar.sv
module operand_xbar #(
    parameter int BITWIDTH = 18
) (
    input  logic signed [BITWIDTH-1:0]     x0_i,
    input  logic signed [BITWIDTH-1:0]     y0_i,
    input  logic signed [BITWIDTH-1:0]     x1_i,
    input  logic signed [BITWIDTH-1:0]     y1_i,
    input  logic                           swap_in_i,
    input  logic                           swap_out_i,
    input  logic [cordic_pkg::SEG_NUM-1:0] share_i,
    input  logic signed [BITWIDTH-1:0]     cor0_x_i,
    input  logic signed [BITWIDTH-1:0]     cor0_y_i,
    input  logic signed [BITWIDTH-1:0]     cor1_x_i,
    input  logic signed [BITWIDTH-1:0]     cor1_y_i,
    input  cordic_pkg::dir_word_u          dir0_i,
    input  cordic_pkg::dir_word_u          dir1_i,
    output logic signed [BITWIDTH-1:0]     cor0_x_o,
    output logic signed [BITWIDTH-1:0]     cor0_y_o,
    output logic signed [BITWIDTH-1:0]     cor1_x_o,
    output logic signed [BITWIDTH-1:0]     cor1_y_o,
    output logic signed [BITWIDTH-1:0]     x0_o,
    output logic signed [BITWIDTH-1:0]     y0_o,
    output logic signed [BITWIDTH-1:0]     x1_o,
    output logic signed [BITWIDTH-1:0]     y1_o,
    output cordic_pkg::dir_word_u          dir1_o
);
    import cordic_pkg::*;

    // swapped: unit 0 sees (x0, x1), unit 1 sees (y0, y1)
    assign cor0_x_o = x0_i;
    assign cor0_y_o = swap_in_i ? x1_i : y0_i;
    assign cor1_x_o = swap_in_i ? y0_i : x1_i;
    assign cor1_y_o = y1_i;

    assign x0_o = cor0_x_i;
    assign y0_o = swap_out_i ? cor1_x_i : cor0_y_i;  // undo swap at the tail
    assign x1_o = swap_out_i ? cor0_y_i : cor1_x_i;
    assign y1_o = cor1_y_i;

    // unit 1 borrows unit 0's fresh segments while shared
    assign dir1_o = seg_merge(dir0_i, dir1_i, share_i);

endmodule

//--- logic/angle_store.sv
module angle_store (
    input  logic                           clk,
    input  logic                           rst_n,
    input  cordic_pkg::dir_word_u          dir0_i,
    input  cordic_pkg::dir_word_u          dir1_i,
    input  logic [cordic_pkg::SEG_NUM-1:0] val0_i,
    input  logic [cordic_pkg::SEG_NUM-1:0] val1_i,
    output cordic_pkg::dir_word_u          angle0_o,
    output cordic_pkg::dir_word_u          angle1_o
);
    import cordic_pkg::*;

    dir_word_u held0_q;
    dir_word_u held1_q;

    // fresh segments bypass the register in their own cycle
    assign angle0_o = seg_merge(dir0_i, held0_q, val0_i);
    assign angle1_o = seg_merge(dir1_i, held1_q, val1_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held0_q <= '0;
            held1_q <= '0;
        end else begin
            held0_q <= angle0_o;  // only valid segments change
            held1_q <= angle1_o;
        end
    end

endmodule

//--- logic/givens_pe_top.sv
module givens_pe_top #(
    parameter int BITWIDTH = 18
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [1:0]                 valid_i,
    input  pe_pkg::scheme_e            scheme_i,
    input  logic signed [BITWIDTH-1:0] x0_i,
    input  logic signed [BITWIDTH-1:0] y0_i,
    input  logic signed [BITWIDTH-1:0] x1_i,
    input  logic signed [BITWIDTH-1:0] y1_i,
    output logic signed [BITWIDTH-1:0] x0_o,
    output logic signed [BITWIDTH-1:0] y0_o,
    output logic signed [BITWIDTH-1:0] x1_o,
    output logic signed [BITWIDTH-1:0] y1_o,
    output cordic_pkg::dir_word_u      angle0_o,
    output cordic_pkg::dir_word_u      angle1_o
);
    import cordic_pkg::*;
    import pe_pkg::*;

    cordic_mode_e          mode0;
    cordic_mode_e          mode1;
    logic                  swap_in;
    logic                  swap_out;
    logic [SEG_NUM-1:0]    val0;
    logic [SEG_NUM-1:0]    val1;
    logic [SEG_NUM-1:0]    share;
    logic signed [BITWIDTH-1:0] cor0_x_in;
    logic signed [BITWIDTH-1:0] cor0_y_in;
    logic signed [BITWIDTH-1:0] cor1_x_in;
    logic signed [BITWIDTH-1:0] cor1_y_in;
    logic signed [BITWIDTH-1:0] cor0_x_out;
    logic signed [BITWIDTH-1:0] cor0_y_out;
    logic signed [BITWIDTH-1:0] cor1_x_out;
    logic signed [BITWIDTH-1:0] cor1_y_out;
    dir_word_u             dir0;
    dir_word_u             dir1_raw;
    dir_word_u             dir1;

    pe_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (valid_i),
        .scheme_i   (scheme_i),
        .mode0_o    (mode0),
        .mode1_o    (mode1),
        .swap_in_o  (swap_in),
        .swap_out_o (swap_out),
        .val0_o     (val0),
        .val1_o     (val1),
        .share_o    (share)
    );

    operand_xbar #(.BITWIDTH(BITWIDTH)) u_xbar (
        .x0_i       (x0_i),
        .y0_i       (y0_i),
        .x1_i       (x1_i),
        .y1_i       (y1_i),
        .swap_in_i  (swap_in),
        .swap_out_i (swap_out),
        .share_i    (share),
        .cor0_x_i   (cor0_x_out),
        .cor0_y_i   (cor0_y_out),
        .cor1_x_i   (cor1_x_out),
        .cor1_y_i   (cor1_y_out),
        .dir0_i     (dir0),
        .dir1_i     (dir1_raw),
        .cor0_x_o   (cor0_x_in),
        .cor0_y_o   (cor0_y_in),
        .cor1_x_o   (cor1_x_in),
        .cor1_y_o   (cor1_y_in),
        .x0_o       (x0_o),
        .y0_o       (y0_o),
        .x1_o       (x1_o),
        .y1_o       (y1_o),
        .dir1_o     (dir1)
    );

    // merged angles feed both the units and the outputs
    angle_store u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .dir0_i   (dir0),
        .dir1_i   (dir1),
        .val0_i   (val0),
        .val1_i   (val1),
        .angle0_o (angle0_o),
        .angle1_o (angle1_o)
    );

    cordic_pipe #(.BITWIDTH(BITWIDTH)) u_cor0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (valid_i[0]),
        .mode_i  (mode0),
        .x_i     (cor0_x_in),
        .y_i     (cor0_y_in),
        .d_i     (angle0_o),
        .x_o     (cor0_x_out),
        .y_o     (cor0_y_out),
        .d_o     (dir0)
    );

    cordic_pipe #(.BITWIDTH(BITWIDTH)) u_cor1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (valid_i[1]),
        .mode_i  (mode1),
        .x_i     (cor1_x_in),
        .y_i     (cor1_y_in),
        .d_i     (angle1_o),
        .x_o     (cor1_x_out),
        .y_o     (cor1_y_out),
        .d_o     (dir1_raw)
    );

endmodule

//--- bench/givens_pe_props.sv
module givens_pe_props (
    input logic                           clk,
    input logic                           rst_n,
    input logic [1:0]                     valid_i,
    input pe_pkg::scheme_e                scheme_i,
    input logic                           swap_in_o,
    input logic                           swap_out_o,
    input logic [cordic_pkg::SEG_NUM-1:0] val0_o,
    input logic [cordic_pkg::SEG_NUM-1:0] val1_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import pe_pkg::*;

    int fail_cnt = 0;

    // rotate-only scheme never starts a unit 1 angle
    a_no_val1_rot: assert property (@(posedge clk) disable iff (!rst_n)
        (scheme_i == SCH_ROT_ROT) |-> !val1_o[0])
        else begin
            $error("val1 set in rotate scheme");
            fail_cnt++;
        end

    // compared 4 ticks on, so the history always exists
    a_swap_delay: assert property (@(posedge clk) disable iff (!rst_n)
        ##4 (swap_out_o == $past(swap_in_o, 4)))
        else begin
            $error("swap out is not swap in delayed by 4");
            fail_cnt++;
        end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_i == 2'b00) |-> (!val0_o[0] && !val1_o[0]))
        else begin
            $error("segment valid without a start");
            fail_cnt++;
        end

endmodule

bind pe_ctrl givens_pe_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .scheme_i   (scheme_i),
    .swap_in_o  (swap_in_o),
    .swap_out_o (swap_out_o),
    .val0_o     (val0_o),
    .val1_o     (val1_o)
);

//--- bench/givens_pe_tb.sv
module givens_pe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BW        = 18;
    localparam int MAX_CASES = 32;
    localparam int LAT       = 4;    // issue to data out
    localparam int DRAIN_MAX = 20;

    logic                 clk;
    logic                 rst_n;
    logic [1:0]           valid;
    pe_pkg::scheme_e      scheme;
    logic signed [BW-1:0] x0;
    logic signed [BW-1:0] y0;
    logic signed [BW-1:0] x1;
    logic signed [BW-1:0] y1;
    logic signed [BW-1:0] x0_o;
    logic signed [BW-1:0] y0_o;
    logic signed [BW-1:0] x1_o;
    logic signed [BW-1:0] y1_o;
    logic [13:0]          angle0;
    logic [13:0]          angle1;

    reg [8*24-1:0] c_name [MAX_CASES];
    logic [1:0]    c_valid [MAX_CASES];
    logic [1:0]    c_scheme [MAX_CASES];
    logic [BW-1:0] c_in [MAX_CASES][4];
    logic [BW-1:0] c_exp [MAX_CASES][4];
    logic [13:0]   c_ang [MAX_CASES][2];
    logic          c_wait [MAX_CASES];   // drain pipe before next case

    int n_cases;
    int errors;
    int checks;
    int assert_fails;
    int cyc;
    int due_q[$];
    int idx_q[$];

    givens_pe_top #(.BITWIDTH(BW)) dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (valid),
        .scheme_i (scheme),
        .x0_i     (x0),
        .y0_i     (y0),
        .x1_i     (x1),
        .y1_i     (y1),
        .x0_o     (x0_o),
        .y0_o     (y0_o),
        .x1_o     (x1_o),
        .y1_o     (y1_o),
        .angle0_o (angle0),
        .angle1_o (angle1)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc = cyc + 1;
        end
    end

    task automatic load_cases();
        integer        fd;
        integer        r;
        int            n;
        reg [8*256-1:0] line;
        reg [8*24-1:0] nm;
        logic [31:0]   f [13];
        n_cases = 0;
        fd = $fopen("bench/givens_pe_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            errors++;
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = '0;
            r = $fgets(line, fd);
            if (r == 0) begin
                break;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", nm,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12]);
            if (n == 14) begin   // comment and blank lines fall through
                c_name[n_cases]   = nm;
                c_valid[n_cases]  = f[0][1:0];
                c_scheme[n_cases] = f[1][1:0];
                for (int k = 0; k < 4; k++) begin
                    c_in[n_cases][k]  = f[2+k][BW-1:0];
                    c_exp[n_cases][k] = f[6+k][BW-1:0];
                end
                c_ang[n_cases][0] = f[10][13:0];
                c_ang[n_cases][1] = f[11][13:0];
                c_wait[n_cases]   = f[12][0];
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_value(input reg [8*24-1:0] name, input string what,
                               input logic [BW-1:0] exp, input logic [BW-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %0s %0s expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_case(input int i);
        check_value(c_name[i], "x0_o", c_exp[i][0], x0_o);
        check_value(c_name[i], "y0_o", c_exp[i][1], y0_o);
        check_value(c_name[i], "x1_o", c_exp[i][2], x1_o);
        check_value(c_name[i], "y1_o", c_exp[i][3], y1_o);
        check_value(c_name[i], "angle0_o", {4'h0, c_ang[i][0]}, {4'h0, angle0});
        check_value(c_name[i], "angle1_o", {4'h0, c_ang[i][1]}, {4'h0, angle1});
    endtask

    // everything cleared, before any edge reloads a register
    task automatic check_zero_outputs(input reg [8*24-1:0] name);
        check_value(name, "x0_o", '0, x0_o);
        check_value(name, "y0_o", '0, y0_o);
        check_value(name, "x1_o", '0, x1_o);
        check_value(name, "y1_o", '0, y1_o);
        check_value(name, "angle0_o", '0, {4'h0, angle0});
        check_value(name, "angle1_o", '0, {4'h0, angle1});
    endtask

    // results are sampled just after the edge that loads the output regs
    initial begin
        forever begin
            @(posedge clk);
            #1;
            while (due_q.size() > 0 && due_q[0] == cyc) begin
                check_case(idx_q[0]);
                void'(due_q.pop_front());
                void'(idx_q.pop_front());
            end
        end
    end

    task automatic issue(input int i);
        valid  = c_valid[i];
        scheme = pe_pkg::scheme_e'(c_scheme[i]);
        x0     = c_in[i][0];
        y0     = c_in[i][1];
        x1     = c_in[i][2];
        y1     = c_in[i][3];
        due_q.push_back(cyc + LAT);
        idx_q.push_back(i);
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (due_q.size() > 0 && t < DRAIN_MAX) begin
            @(posedge clk);
            t++;
        end
        if (due_q.size() > 0) begin
            errors++;
            $display("timeout, results still pending after %0d cycles", t);
            due_q.delete();
            idx_q.delete();
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        valid  = 2'b00;
        scheme = pe_pkg::SCH_VEC_VEC;
        x0     = '0;
        y0     = '0;
        x1     = '0;
        y1     = '0;
        load_cases();
        if (n_cases == 0) begin
            errors++;
            $display("no cases were read");
        end
        repeat (2) @(posedge clk);
        #5 rst_n = 1'b1;
        check_zero_outputs("after_reset");
        for (int i = 0; i < n_cases; i++) begin
            @(posedge clk);
            #5;
            issue(i);
            if (c_wait[i]) begin
                @(posedge clk);
                #5 valid = 2'b00;
                drain();
            end
        end
        @(posedge clk);
        #5 valid = 2'b00;
        drain();
        assert_fails = dut.u_ctrl.u_props.fail_cnt;
        $display("checks %0d errors %0d assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- bench/givens_pe_cases.txt
# name valid scheme x0 y0 x1 y1 | exp x0 y0 x1 y1 | exp angle0 angle1 | wait
# all values hex, data 18 bit two's complement, wait 1 drains the pipe after the case
reset        0 0 00000 00000 00000 00000 00000 00000 00000 00000 0000 0000 1
vec_pair     3 0 00400 00000 00400 00000 00403 3fffe 00403 3fffe 3f2e 3f2e 1
rot_stored   3 1 00400 00000 00000 00400 00403 3fffe 00001 00400 3f2e 3f2e 1
swap_vec_rot 3 2 00000 00400 00400 00000 00400 3fffe 00001 3fc00 00d0 00d0 1
swap_rot_rot 3 3 00400 00400 00000 00000 3fffe 3fffe 3fc00 3fc00 00d0 00d0 1
b2b_vec      3 0 00400 00000 00400 00000 00403 3fffe 00403 3fffe 3f2e 3f2e 0
b2b_rot_a    3 1 00400 00000 00000 00400 00403 3fffe 00001 00400 3f2e 3f2e 0
b2b_rot_b    3 1 00000 00400 00400 00000 00001 00400 00403 3fffe 3f2e 3f2e 1

//--- filelist.f
logic/cordic_pkg.sv
logic/pe_pkg.sv
logic/cordic_pipe.sv
logic/pe_ctrl.sv
logic/operand_xbar.sv
logic/angle_store.sv
logic/givens_pe_top.sv
bench/givens_pe_props.sv
bench/givens_pe_tb.sv
